//--- source/flight_types_pkg.sv
// Flight path data types
`default_nettype none

package flight_types_pkg;

  // rate word width, q12.4 two's complement.
  localparam int RATE_W = 16;

  // motor rate width, duty in 1/256 of a frame.
  localparam int MOTOR_RATE_W = 8;

  // quad x frame.
  localparam int NUM_MOTORS = 4;

  // signed rate from the rate controllers, 12 integer and 4 fraction bits.
  typedef logic signed [RATE_W-1:0] rate_t;

  // unsigned motor rate, applied as pwm duty.
  typedef logic [MOTOR_RATE_W-1:0] motor_rate_t;

  // largest positive rate, +2047.9375.
  localparam rate_t RATE_MAX = 16'sh7fff;

  // most negative rate, -2048.0; has no positive counterpart.
  localparam rate_t RATE_MIN = 16'sh8000;

endpackage

`default_nettype wire

//--- source/mixer_cfg_pkg.sv
// Mixer configuration
`default_nettype none

package mixer_cfg_pkg;

  // 16.0 in q12.4, added to every motor.
  localparam flight_types_pkg::rate_t MOTOR_RATE_BIAS = 16'sh0100;

  // fraction bits dropped when mapping to a motor rate.
  localparam int MAP_SHIFT = 4;

  // half an lsb of the mapped value, gives round half up.
  localparam int MAP_ROUND = 8;

  // allowed band for a mapped motor rate.
  localparam int MOTOR_VAL_MIN = 8;
  localparam int MOTOR_VAL_MAX = 240;

  // sign table, bit n is motor n+1, a set bit negates the axis.
  // motors 1 and 4 spin ccw, motors 2 and 3 spin cw.
  localparam logic [3:0] SIGN_YAW   = 4'b1001; // m1 -, m2 +, m3 +, m4 -.
  localparam logic [3:0] SIGN_ROLL  = 4'b1010; // m1 +, m2 -, m3 +, m4 -.
  localparam logic [3:0] SIGN_PITCH = 4'b0011; // m1 -, m2 -, m3 +, m4 +.

  // mixer pipeline stages, also the index of each stage valid bit.
  typedef enum logic [1:0] {
    MIX_SIGN    = 2'd0, // sign-applied axis inputs.
    MIX_SUM_MAP = 2'd1, // summed, saturated and mapped.
    MIX_SEND    = 2'd2  // band-checked command on the bus.
  } mix_stage_t;

endpackage

`default_nettype wire

//--- source/motor_cmd_if.sv
// Motor command bus
`timescale 1ns/10ps
`default_nettype none

interface motor_cmd_if;

  flight_types_pkg::motor_rate_t motor_rate [flight_types_pkg::NUM_MOTORS]; // one per motor.
  logic cmd_valid; // command held stable until taken.
  logic cmd_ready; // pwm side at a frame boundary.

  // mixer side.
  modport source (
    output motor_rate,
    output cmd_valid,
    input  cmd_ready
  );

  // pwm generator side.
  modport sink (
    input  motor_rate,
    input  cmd_valid,
    output cmd_ready
  );

endinterface

`default_nettype wire

//--- source/motor_rate_calculator.sv
// Single motor rate sum
`timescale 1ns/10ps
`default_nettype none

module motor_rate_calculator (
  input  flight_types_pkg::rate_t bias,
  input  flight_types_pkg::rate_t throttle_rate,
  input  flight_types_pkg::rate_t yaw_rate,
  input  flight_types_pkg::rate_t roll_rate,
  input  flight_types_pkg::rate_t pitch_rate,
  output flight_types_pkg::rate_t motor_rate
);

  // five 16 bit terms never overflow 19 bits.
  localparam int SUM_W = flight_types_pkg::RATE_W + 3;
  localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'(flight_types_pkg::RATE_MAX);

  logic signed [SUM_W-1:0] bias_x;     // sign-extended terms.
  logic signed [SUM_W-1:0] thr_x;
  logic signed [SUM_W-1:0] half_yaw;
  logic signed [SUM_W-1:0] half_roll;
  logic signed [SUM_W-1:0] half_pitch;
  logic signed [SUM_W-1:0] sum;

  assign bias_x     = bias;
  assign thr_x      = throttle_rate;
  assign half_yaw   = yaw_rate >>> 1;   // arithmetic halving, rounds toward -inf.
  assign half_roll  = roll_rate >>> 1;
  assign half_pitch = pitch_rate >>> 1;

  assign sum = bias_x + thr_x + half_yaw + half_roll + half_pitch;

  // clamp to 0 .. rate max, a motor cannot spin backwards.
  always_comb begin
    if (sum < 0) begin
      motor_rate = '0;
    end else if (sum > SUM_MAX) begin
      motor_rate = flight_types_pkg::RATE_MAX;
    end else begin
      motor_rate = sum[flight_types_pkg::RATE_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- source/motor_mixer.sv
// X-frame motor mixer
`timescale 1ns/10ps
`default_nettype none

module motor_mixer (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  flight_types_pkg::rate_t throttle_rate,
  input  flight_types_pkg::rate_t yaw_rate,
  input  flight_types_pkg::rate_t roll_rate,
  input  flight_types_pkg::rate_t pitch_rate,
  input  logic                    rate_valid,
  output logic                    rate_ready,
  motor_cmd_if.source             cmd
);

  localparam int NM      = flight_types_pkg::NUM_MOTORS;
  localparam int RATE_W  = flight_types_pkg::RATE_W;
  localparam int MR_W    = flight_types_pkg::MOTOR_RATE_W;
  localparam int MAP_W   = 12; // mapped value before the band check.

  // valid bit per stage, indexed by stage name.
  logic [2:0] stage_vld;
  logic       accept;  // rate set taken into stage 1.
  logic       adv1;    // stage 1 moves to stage 2.
  logic       adv2;    // stage 2 moves to stage 3.
  logic       adv3;    // stage 3 handed to the pwm side.

  // stage 1 payload.
  flight_types_pkg::rate_t s1_thr;
  flight_types_pkg::rate_t s1_yaw   [NM];
  flight_types_pkg::rate_t s1_roll  [NM];
  flight_types_pkg::rate_t s1_pitch [NM];

  // calculator outputs and stage 2 payload.
  flight_types_pkg::rate_t calc_out [NM];
  logic [MAP_W-1:0]        map_next [NM];
  logic [MAP_W-1:0]        s2_map   [NM];

  // band check and hold values.
  logic [NM-1:0]                 in_band;
  flight_types_pkg::motor_rate_t last_rate [NM];

  // negate on a set sign bit, -2048.0 goes to +max instead of wrapping.
  function automatic flight_types_pkg::rate_t apply_sign(input logic neg,
                                                         input flight_types_pkg::rate_t x);
    if (!neg) begin
      return x;
    end
    if (x == flight_types_pkg::RATE_MIN) begin
      return flight_types_pkg::RATE_MAX;
    end
    return -x;
  endfunction

  // a stage moves when the next one is empty or emptying this cycle.
  assign adv3   = stage_vld[mixer_cfg_pkg::MIX_SEND] & cmd.cmd_ready;
  assign adv2   = stage_vld[mixer_cfg_pkg::MIX_SUM_MAP]
                & (~stage_vld[mixer_cfg_pkg::MIX_SEND] | adv3);
  assign adv1   = stage_vld[mixer_cfg_pkg::MIX_SIGN]
                & (~stage_vld[mixer_cfg_pkg::MIX_SUM_MAP] | adv2);
  assign rate_ready = ~stage_vld[mixer_cfg_pkg::MIX_SIGN] | adv1;
  assign accept     = rate_valid & rate_ready;

  assign cmd.cmd_valid = stage_vld[mixer_cfg_pkg::MIX_SEND]; // held until taken.

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_vld <= '0;
    end else begin
      stage_vld[mixer_cfg_pkg::MIX_SIGN] <= accept
        | (stage_vld[mixer_cfg_pkg::MIX_SIGN] & ~adv1);
      stage_vld[mixer_cfg_pkg::MIX_SUM_MAP] <= adv1
        | (stage_vld[mixer_cfg_pkg::MIX_SUM_MAP] & ~adv2);
      stage_vld[mixer_cfg_pkg::MIX_SEND] <= adv2
        | (stage_vld[mixer_cfg_pkg::MIX_SEND] & ~adv3);
    end
  end

  // stage 1, per motor signed copies of each axis.
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      s1_thr <= throttle_rate;
      for (int m = 0; m < NM; m++) begin
        s1_yaw[m]   <= apply_sign(mixer_cfg_pkg::SIGN_YAW[m], yaw_rate);
        s1_roll[m]  <= apply_sign(mixer_cfg_pkg::SIGN_ROLL[m], roll_rate);
        s1_pitch[m] <= apply_sign(mixer_cfg_pkg::SIGN_PITCH[m], pitch_rate);
      end
    end
  end

  for (genvar g = 0; g < NM; g++) begin : g_motor
    logic [RATE_W:0] rounded; // one spare bit for the rounding add.

    motor_rate_calculator motor_rate_calculator_i (
      .bias          (mixer_cfg_pkg::MOTOR_RATE_BIAS),
      .throttle_rate (s1_thr),
      .yaw_rate      (s1_yaw[g]),
      .roll_rate     (s1_roll[g]),
      .pitch_rate    (s1_pitch[g]),
      .motor_rate    (calc_out[g])
    );

    // sum is never negative here, so treat it as unsigned.
    assign rounded     = {1'b0, calc_out[g]} + (RATE_W+1)'(mixer_cfg_pkg::MAP_ROUND);
    assign map_next[g] = rounded[mixer_cfg_pkg::MAP_SHIFT +: MAP_W]; // drop fraction.

    assign in_band[g] = (s2_map[g] >= MAP_W'(mixer_cfg_pkg::MOTOR_VAL_MIN))
                      && (s2_map[g] <= MAP_W'(mixer_cfg_pkg::MOTOR_VAL_MAX));
  end

  // stage 2, mapped values.
  always_ff @(posedge sys_clk) begin
    if (adv1) begin
      s2_map <= map_next;
    end
  end

  // stage 3, out of band motors repeat their last good rate.
  always_ff @(posedge sys_clk) begin
    if (adv2) begin
      for (int m = 0; m < NM; m++) begin
        cmd.motor_rate[m] <= in_band[m] ? s2_map[m][MR_W-1:0] : last_rate[m];
      end
    end
  end

  // updated only on the move into stage 3, keeps order with the commands.
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < NM; m++) begin
        last_rate[m] <= '0;
      end
    end else if (adv2) begin
      for (int m = 0; m < NM; m++) begin
        if (in_band[m]) begin
          last_rate[m] <= s2_map[m][MR_W-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/pwm_generator.sv
// Four channel frame PWM
`timescale 1ns/10ps
`default_nettype none

module pwm_generator #(
  parameter int PWM_PRESCALE = 4 // sys_clk cycles per pwm step.
) (
  input  logic                          sys_clk,
  input  logic                          rst_n,
  motor_cmd_if.sink                     cmd,
  output logic [3:0]                    motor_pwm,
  output flight_types_pkg::motor_rate_t duty [flight_types_pkg::NUM_MOTORS]
);

  localparam int NM    = flight_types_pkg::NUM_MOTORS;
  localparam int PRE_W = (PWM_PRESCALE > 1) ? $clog2(PWM_PRESCALE) : 1;

  logic [PRE_W-1:0] pre_cnt;   // cycles within a step.
  logic [7:0]       step_cnt;  // step within the 256 step frame.
  logic             step_end;
  logic             frame_end;

  assign step_end  = (pre_cnt == PRE_W'(PWM_PRESCALE - 1));
  assign frame_end = step_end & (step_cnt == 8'hff);

  // new commands only at the frame boundary, no mid-frame duty change.
  assign cmd.cmd_ready = frame_end;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt  <= '0;
      step_cnt <= '0;
    end else if (step_end) begin
      pre_cnt  <= '0;
      step_cnt <= step_cnt + 8'd1; // wraps to step 0 of the next frame.
    end else begin
      pre_cnt  <= pre_cnt + PRE_W'(1);
    end
  end

  // duty loaded in the last cycle, valid from the first cycle of the next frame.
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int m = 0; m < NM; m++) begin
        duty[m] <= '0;
      end
    end else if (frame_end && cmd.cmd_valid) begin
      for (int m = 0; m < NM; m++) begin
        duty[m] <= cmd.motor_rate[m];
      end
    end
  end

  // high while the step is below duty, duty 0 keeps the line low.
  always_comb begin
    motor_pwm = '0;
    for (int m = 0; m < NM; m++) begin
      motor_pwm[m] = (step_cnt < duty[m]);
    end
  end

endmodule

`default_nettype wire

//--- source/flight_mixer_top.sv
// Flight mixer top level
`timescale 1ns/10ps
`default_nettype none

module flight_mixer_top #(
  parameter int PWM_PRESCALE = 4 // sys_clk cycles per pwm step.
) (
  input  logic                          sys_clk,
  input  logic                          rst_n,
  input  flight_types_pkg::rate_t       throttle_rate,
  input  flight_types_pkg::rate_t       yaw_rate,
  input  flight_types_pkg::rate_t       roll_rate,
  input  flight_types_pkg::rate_t       pitch_rate,
  input  logic                          rate_valid,
  output logic                          rate_ready,
  output logic [3:0]                    motor_pwm,
  output flight_types_pkg::motor_rate_t motor_1_rate,
  output flight_types_pkg::motor_rate_t motor_2_rate,
  output flight_types_pkg::motor_rate_t motor_3_rate,
  output flight_types_pkg::motor_rate_t motor_4_rate
);

  flight_types_pkg::motor_rate_t duty [flight_types_pkg::NUM_MOTORS]; // applied rates.

  // mixer to pwm command path.
  motor_cmd_if motor_cmd_if_i ();

  motor_mixer motor_mixer_i (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .throttle_rate (throttle_rate),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .rate_valid    (rate_valid),
    .rate_ready    (rate_ready),
    .cmd           (motor_cmd_if_i.source)
  );

  pwm_generator #(
    .PWM_PRESCALE (PWM_PRESCALE)
  ) pwm_generator_i (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .cmd       (motor_cmd_if_i.sink),
    .motor_pwm (motor_pwm),
    .duty      (duty)
  );

  // telemetry, the duty in force this frame.
  assign motor_1_rate = duty[0];
  assign motor_2_rate = duty[1];
  assign motor_3_rate = duty[2];
  assign motor_4_rate = duty[3];

endmodule

`default_nettype wire

//--- test/tb_flight_mixer.sv
// Flight mixer testbench
`timescale 1ns/10ps
`default_nettype none

module tb_flight_mixer;

  localparam int CLK_PERIOD   = 20;  // ns.
  localparam int FRAME_CYCLES = 256; // prescale 1, one step per cycle.
  localparam int NUM_TESTS    = 6;
  localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 8;  // longest handshake wait.
  localparam int WATCHDOG_NS  = NUM_TESTS * 4 * FRAME_CYCLES * CLK_PERIOD + 20000;
  localparam int BP_SETS      = 8;

  logic                          sys_clk;
  logic                          rst_n;
  flight_types_pkg::rate_t       throttle_rate;
  flight_types_pkg::rate_t       yaw_rate;
  flight_types_pkg::rate_t       roll_rate;
  flight_types_pkg::rate_t       pitch_rate;
  logic                          rate_valid;
  logic                          rate_ready;
  logic [3:0]                    motor_pwm;
  flight_types_pkg::motor_rate_t motor_1_rate;
  flight_types_pkg::motor_rate_t motor_2_rate;
  flight_types_pkg::motor_rate_t motor_3_rate;
  flight_types_pkg::motor_rate_t motor_4_rate;

  int     errors;
  int     checks;
  integer seed;
  logic   stall_seen;   // rate_ready seen low while offering.
  int     pwm_cnt [4];  // measured high cycles per channel.
  flight_types_pkg::motor_rate_t model_last [4]; // model copy of the hold registers.
  flight_types_pkg::motor_rate_t last_exp [4];   // last checked duty per motor.
  flight_types_pkg::motor_rate_t exp_q [$];      // four entries per accepted set.

  flight_mixer_top #(
    .PWM_PRESCALE (1)
  ) flight_mixer_top_i (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .throttle_rate (throttle_rate),
    .yaw_rate      (yaw_rate),
    .roll_rate     (roll_rate),
    .pitch_rate    (pitch_rate),
    .rate_valid    (rate_valid),
    .rate_ready    (rate_ready),
    .motor_pwm     (motor_pwm),
    .motor_1_rate  (motor_1_rate),
    .motor_2_rate  (motor_2_rate),
    .motor_3_rate  (motor_3_rate),
    .motor_4_rate  (motor_4_rate)
  );

  initial sys_clk = 1'b0;
  always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

  // negation saturates, -2048.0 turns into +max.
  function automatic int signed_axis(input logic neg, input flight_types_pkg::rate_t x);
    if (!neg) return int'(x);
    if (x == 16'sh8000) return 32767;
    return -int'(x);
  endfunction

  // bias, throttle and halved axes, clamped, then round half up to 12 bits.
  function automatic int mapped_rate(input int m, input flight_types_pkg::rate_t thr,
                                     input flight_types_pkg::rate_t yaw,
                                     input flight_types_pkg::rate_t roll,
                                     input flight_types_pkg::rate_t pitch);
    int sum;
    sum = int'(mixer_cfg_pkg::MOTOR_RATE_BIAS) + int'(thr)
        + (signed_axis(mixer_cfg_pkg::SIGN_YAW[m], yaw) >>> 1)
        + (signed_axis(mixer_cfg_pkg::SIGN_ROLL[m], roll) >>> 1)
        + (signed_axis(mixer_cfg_pkg::SIGN_PITCH[m], pitch) >>> 1);
    if (sum < 0) sum = 0;
    else if (sum > 32767) sum = 32767;
    return ((sum + mixer_cfg_pkg::MAP_ROUND) >>> mixer_cfg_pkg::MAP_SHIFT) & 32'hfff;
  endfunction

  // band check with last value hold, queues the expected duties in order.
  function void record_expected(input flight_types_pkg::rate_t thr,
                                input flight_types_pkg::rate_t yaw,
                                input flight_types_pkg::rate_t roll,
                                input flight_types_pkg::rate_t pitch);
    int mapped;
    for (int m = 0; m < 4; m++) begin
      mapped = mapped_rate(m, thr, yaw, roll, pitch);
      if (mapped >= mixer_cfg_pkg::MOTOR_VAL_MIN && mapped <= mixer_cfg_pkg::MOTOR_VAL_MAX) begin
        model_last[m] = flight_types_pkg::motor_rate_t'(mapped);
      end
      exp_q.push_back(model_last[m]);
    end
  endfunction

  function automatic flight_types_pkg::motor_rate_t applied_rate(input int m);
    case (m)
      0:       return motor_1_rate;
      1:       return motor_2_rate;
      2:       return motor_3_rate;
      default: return motor_4_rate;
    endcase
  endfunction

  function automatic string rate_name(input int m);
    return $sformatf("motor_%0d_rate", m + 1);
  endfunction

  // debug view of mixer stage occupancy.
  function void show_pipeline();
    mixer_cfg_pkg::mix_stage_t st;
    for (int s = 0; s < 3; s++) begin
      st = mixer_cfg_pkg::mix_stage_t'(s);
      $display("  stage %s valid %0b", st.name(), flight_mixer_top_i.motor_mixer_i.stage_vld[s]);
    end
  endfunction

  function automatic flight_types_pkg::rate_t rand_axis();
    return flight_types_pkg::rate_t'(($random(seed) & 32'h03ff) - 32'h0200); // +-32.0.
  endfunction

  task automatic check_motor_rate(input string name, input flight_types_pkg::motor_rate_t got,
                                  input flight_types_pkg::motor_rate_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, want);
    end
  endtask

  task automatic check_pwm_high(input string name, input int got, input int want);
    checks++;
    if (got != want) begin
      errors++;
      $display("[FAIL] %s high cycles: got 0x%0h expected 0x%0h", name, got, want);
    end
  endtask

  task automatic check_bits(input string name, input logic [3:0] got, input logic [3:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %s: got 0x%01h expected 0x%01h", name, got, want);
    end
  endtask

  // call at a rising edge, returns on the edge that takes the set.
  task automatic offer_set(input flight_types_pkg::rate_t thr, input flight_types_pkg::rate_t yaw,
                           input flight_types_pkg::rate_t roll,
                           input flight_types_pkg::rate_t pitch);
    int   wait_cnt;
    logic taken;
    throttle_rate <= thr;
    yaw_rate      <= yaw;
    roll_rate     <= roll;
    pitch_rate    <= pitch;
    rate_valid    <= 1'b1;
    taken    = 1'b0;
    wait_cnt = 0;
    while (!taken && wait_cnt < WAIT_LIMIT) begin
      @(negedge sys_clk);
      taken = rate_ready;
      if (!taken && !stall_seen) begin
        stall_seen = 1'b1;
        $display("rate input stalled at %0t ns", $time);
        show_pipeline();
      end
      wait_cnt++;
    end
    if (!taken) begin
      errors++;
      $display("rate set was never accepted by the mixer");
    end else begin
      record_expected(thr, yaw, roll, pitch);
    end
    @(posedge sys_clk);
  endtask

  // waits for the command transfer, returns in the first cycle of the new frame.
  task automatic wait_cmd_taken();
    int   wait_cnt;
    logic taken;
    taken    = 1'b0;
    wait_cnt = 0;
    while (!taken && wait_cnt < WAIT_LIMIT) begin
      @(negedge sys_clk);
      taken = flight_mixer_top_i.motor_cmd_if_i.cmd_valid
            & flight_mixer_top_i.motor_cmd_if_i.cmd_ready;
      wait_cnt++;
    end
    if (!taken) begin
      errors++;
      $display("no command reached the pwm generator within %0d cycles", WAIT_LIMIT);
    end else begin
      @(posedge sys_clk);
      @(negedge sys_clk);
    end
  endtask

  task automatic check_applied();
    for (int m = 0; m < 4; m++) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a command was applied with no expected values left");
      end else begin
        last_exp[m] = exp_q.pop_front();
        check_motor_rate(rate_name(m), applied_rate(m), last_exp[m]);
      end
    end
  endtask

  task automatic run_set(input flight_types_pkg::rate_t thr, input flight_types_pkg::rate_t yaw,
                         input flight_types_pkg::rate_t roll,
                         input flight_types_pkg::rate_t pitch);
    @(posedge sys_clk);
    offer_set(thr, yaw, roll, pitch);
    rate_valid <= 1'b0;
    wait_cmd_taken();
    check_applied();
  endtask

  task automatic reset_state();
    for (int m = 0; m < 4; m++) begin
      check_motor_rate(rate_name(m), applied_rate(m), 8'h00);
    end
    check_bits("motor_pwm", motor_pwm, 4'h0);
    check_bits("rate_ready", {3'b000, rate_ready}, 4'h1);
  endtask

  task automatic hover();
    run_set(16'sh0400, 16'sh0000, 16'sh0000, 16'sh0000); // 64.0 throttle, 80 per motor.
    check_motor_rate("motor_1_rate", motor_1_rate, 8'd80);
    for (int m = 0; m < 4; m++) begin
      pwm_cnt[m] = 0;
    end
    for (int s = 0; s < FRAME_CYCLES; s++) begin
      if (s > 0) @(negedge sys_clk);
      for (int m = 0; m < 4; m++) begin
        if (motor_pwm[m]) pwm_cnt[m]++;
      end
    end
    for (int m = 0; m < 4; m++) begin
      check_pwm_high($sformatf("motor_pwm[%0d]", m), pwm_cnt[m], int'(last_exp[m]));
    end
  endtask

  task automatic axis_signs();
    run_set(16'sh0400, 16'sh0100, 16'sh0000, 16'sh0000); // yaw 16.0, +-8 per motor.
    run_set(16'sh0400, 16'sh0000, 16'sh0100, 16'sh0000);
    run_set(16'sh0400, 16'sh0000, 16'sh0000, 16'sh0100);
    run_set(16'sh0400, -16'sh0100, 16'sh0000, 16'sh0000);
  endtask

  task automatic band_hold();
    run_set(16'sh0400, 16'sh0000, 16'sh0000, 16'sh0000);
    run_set(16'sh0400, 16'sh0dc0, 16'sh0640, 16'sh0640); // m3 at 290, m1 and m4 below 0.
    check_motor_rate("motor_1_rate", motor_1_rate, 8'd80);
    check_motor_rate("motor_2_rate", motor_2_rate, 8'd90);
    check_motor_rate("motor_3_rate", motor_3_rate, 8'd80);
    check_motor_rate("motor_4_rate", motor_4_rate, 8'd80);
  endtask

  task automatic saturation_rounding();
    run_set(16'sh8000, 16'sh0000, 16'sh0000, 16'sh0000); // sum clamps to 0, all hold.
    run_set(16'shc541, 16'sh8000, 16'sh0000, 16'sh0000); // m1 and m4 reach 100 via +max yaw.
    check_motor_rate("motor_1_rate", motor_1_rate, 8'd100);
    check_motor_rate("motor_4_rate", motor_4_rate, 8'd100);
    run_set(16'sh0408, 16'sh0000, 16'sh0000, 16'sh0000); // 80.5 rounds up.
    check_motor_rate("motor_1_rate", motor_1_rate, 8'd81);
  endtask

  task automatic back_pressure();
    stall_seen = 1'b0;
    fork
      begin
        @(posedge sys_clk);
        for (int i = 0; i < BP_SETS; i++) begin
          offer_set(flight_types_pkg::rate_t'(32'h0200 + ($random(seed) & 32'h07ff)),
                    rand_axis(), rand_axis(), rand_axis());
        end
        rate_valid <= 1'b0;
      end
      begin
        for (int i = 0; i < BP_SETS; i++) begin
          wait_cmd_taken();
          check_applied();
        end
      end
    join
    if (!stall_seen) begin
      errors++;
      $display("rate_ready never fell while the pwm stage was busy");
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    rst_n         <= 1'b0;
    throttle_rate <= '0;
    yaw_rate      <= '0;
    roll_rate     <= '0;
    pitch_rate    <= '0;
    rate_valid    <= 1'b0;
    errors     = 0;
    checks     = 0;
    seed       = 32'hf2e3dbe5;
    stall_seen = 1'b0;
    for (int m = 0; m < 4; m++) begin
      model_last[m] = '0;
      last_exp[m]   = '0;
    end
    repeat (16) @(posedge sys_clk);
    rst_n <= 1'b1;
    @(negedge sys_clk);
    reset_state();
    hover();
    axis_signs();
    band_hold();
    saturation_rounding();
    back_pressure();
    $display("run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
source/flight_types_pkg.sv
source/mixer_cfg_pkg.sv
source/motor_cmd_if.sv
source/motor_rate_calculator.sv
source/motor_mixer.sv
source/pwm_generator.sv
source/flight_mixer_top.sv
test/tb_flight_mixer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the flight mixer testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module tb_flight_mixer -o tb_flight_mixer \
  && ./obj_dir/tb_flight_mixer | tee sim.log \
  && grep -q "Verification passed" sim.log \
  && echo "simulation run: PASS" \
  || { echo "simulation run: FAIL"; exit 1; }
